// File: design/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    localparam int NBITS       = 32;
    localparam int REG_SEL_W   = 5;
    localparam int IN_DEPTH    = 4;                      // Also the source's starting credits
    localparam int OUT_CREDITS = 2;                      // Records the sink can take

    localparam int IN_PTR_W   = $clog2(IN_DEPTH);
    localparam int IN_CNT_W   = $clog2(IN_DEPTH + 1);
    localparam int OUT_CRED_W = $clog2(OUT_CREDITS + 1);

    // Major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // R-type function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_t;

    typedef enum logic {
        EXT_SIGN, EXT_ZERO
    } ext_mode_t;

    typedef struct packed {
        logic [NBITS-1:0]     pc;
        logic [REG_SEL_W-1:0] rs;
        logic [REG_SEL_W-1:0] rt;
        logic [REG_SEL_W-1:0] dst;
        logic [15:0]          imm;
        logic [4:0]           sa;
        alu_op_t              alu_op;
        logic                 imm_as_b;                  // B from immediate, not rt
        logic                 sa_as_a;                   // A from shift amount, not rs
        ext_mode_t            ext;
        logic                 wr_en;
        logic                 illegal;
    } dec_t;

    typedef struct packed {
        logic [NBITS-1:0]     pc;
        logic [NBITS-1:0]     opnd_a;
        logic [NBITS-1:0]     opnd_b;
        alu_op_t              alu_op;
        logic [REG_SEL_W-1:0] dst;
        logic                 wr_en;
        logic                 illegal;
    } opr_t;

    typedef struct packed {
        logic [NBITS-1:0]     pc;
        logic [NBITS-1:0]     result;
        logic [REG_SEL_W-1:0] dst;
        logic                 wr_en;
        logic                 illegal;
    } exe_t;

    typedef struct packed {
        logic [NBITS-1:0]     pc;
        logic [REG_SEL_W-1:0] dst;
        logic [NBITS-1:0]     result;
        logic                 illegal;
    } wb_rec_t;

endpackage

// File: design/reg_file.sv
module reg_file (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic [cpu_pipe_pkg::REG_SEL_W-1:0] i_rs_sel,
    input  logic [cpu_pipe_pkg::REG_SEL_W-1:0] i_rt_sel,
    input  logic                               i_wr_en,
    input  logic [cpu_pipe_pkg::REG_SEL_W-1:0] i_rd_sel,
    input  logic [cpu_pipe_pkg::NBITS-1:0]     i_wr_data,
    output logic [cpu_pipe_pkg::NBITS-1:0]     o_rs_data,
    output logic [cpu_pipe_pkg::NBITS-1:0]     o_rt_data
);
    import cpu_pipe_pkg::*;

    logic [NBITS-1:0] regs [2**REG_SEL_W-1:1];           // No storage for r0

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 2**REG_SEL_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_rd_sel != '0)) begin
            regs[i_rd_sel] <= i_wr_data;
        end
    end

    // Old value on a same-cycle write
    assign o_rs_data = (i_rs_sel == '0) ? '0 : regs[i_rs_sel];
    assign o_rt_data = (i_rt_sel == '0) ? '0 : regs[i_rt_sel];

endmodule

// File: design/decode_stage.sv
module decode_stage (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_instr_valid,
    input  logic [cpu_pipe_pkg::NBITS-1:0] i_instr,
    input  logic [cpu_pipe_pkg::NBITS-1:0] i_pc,
    input  logic                           i_hold,      // Decode register not taken
    output logic                           o_instr_credit,
    output logic                           o_dec_valid,
    output cpu_pipe_pkg::dec_t             o_dec
);
    import cpu_pipe_pkg::*;

    logic [NBITS-1:0]    fifo_instr [IN_DEPTH];
    logic [NBITS-1:0]    fifo_pc    [IN_DEPTH];
    logic [IN_PTR_W-1:0] wr_ptr;
    logic [IN_PTR_W-1:0] rd_ptr;
    logic [IN_CNT_W-1:0] fifo_cnt;
    logic                pop;
    logic [NBITS-1:0]    head_instr;
    logic [NBITS-1:0]    head_pc;
    logic [5:0]          opcode;
    logic [5:0]          funct;
    dec_t                dec_next;

    assign head_instr = fifo_instr[rd_ptr];
    assign head_pc    = fifo_pc[rd_ptr];
    assign pop        = (fifo_cnt != '0) && (!o_dec_valid || !i_hold);

    // Source only sends with a credit, so the FIFO never overflows
    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            fifo_instr[wr_ptr] <= i_instr;
            fifo_pc[wr_ptr]    <= i_pc;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_cnt       <= '0;
            o_instr_credit <= 1'b0;
        end else begin
            if (i_instr_valid) wr_ptr <= wr_ptr + IN_PTR_W'(1);
            if (pop) rd_ptr <= rd_ptr + IN_PTR_W'(1);
            fifo_cnt       <= fifo_cnt + IN_CNT_W'(i_instr_valid) - IN_CNT_W'(pop);
            o_instr_credit <= pop;                       // One slot freed
        end
    end

    always_comb begin
        opcode          = head_instr[31:26];
        funct           = head_instr[5:0];
        dec_next        = '0;
        dec_next.pc     = head_pc;
        dec_next.rs     = head_instr[25:21];
        dec_next.rt     = head_instr[20:16];
        dec_next.dst    = head_instr[20:16];             // I-type writes rt
        dec_next.imm    = head_instr[15:0];
        dec_next.sa     = head_instr[10:6];
        dec_next.alu_op = ALU_ADD;
        dec_next.ext    = EXT_SIGN;
        dec_next.wr_en  = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                dec_next.dst = head_instr[15:11];
                case (funct)
                    FN_ADDU: dec_next.alu_op = ALU_ADD;
                    FN_SUBU: dec_next.alu_op = ALU_SUB;
                    FN_AND:  dec_next.alu_op = ALU_AND;
                    FN_OR:   dec_next.alu_op = ALU_OR;
                    FN_XOR:  dec_next.alu_op = ALU_XOR;
                    FN_SLT:  dec_next.alu_op = ALU_SLT;
                    FN_SLL: begin
                        dec_next.alu_op  = ALU_SLL;
                        dec_next.sa_as_a = 1'b1;
                    end
                    default: dec_next.illegal = 1'b1;
                endcase
            end
            OP_ADDIU: dec_next.imm_as_b = 1'b1;
            OP_SLTI: begin
                dec_next.alu_op   = ALU_SLT;
                dec_next.imm_as_b = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec_next.imm_as_b = 1'b1;
                dec_next.ext      = EXT_ZERO;
                dec_next.alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                                    (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                dec_next.alu_op   = ALU_LUI;
                dec_next.imm_as_b = 1'b1;
                dec_next.ext      = EXT_ZERO;
            end
            default: dec_next.illegal = 1'b1;
        endcase
        if (dec_next.illegal) begin
            dec_next.wr_en = 1'b0;                       // Record only, no write
            dec_next.dst   = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
        end else if (pop) begin
            o_dec_valid <= 1'b1;
        end else if (!i_hold) begin
            o_dec_valid <= 1'b0;                         // Taken, nothing behind it
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) o_dec <= dec_next;
    end

endmodule

// File: design/operand_stage.sv
module operand_stage (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_dec_valid,
    input  cpu_pipe_pkg::dec_t                 i_dec,
    input  logic                               i_hold,
    input  logic [cpu_pipe_pkg::NBITS-1:0]     i_rs_data,
    input  logic [cpu_pipe_pkg::NBITS-1:0]     i_rt_data,
    input  logic                               i_clr_en,
    input  logic [cpu_pipe_pkg::REG_SEL_W-1:0] i_clr_sel,
    output logic                               o_take,
    output logic [cpu_pipe_pkg::REG_SEL_W-1:0] o_rs_sel,
    output logic [cpu_pipe_pkg::REG_SEL_W-1:0] o_rt_sel,
    output logic                               o_opr_valid,
    output cpu_pipe_pkg::opr_t                 o_opr
);
    import cpu_pipe_pkg::*;

    logic [2**REG_SEL_W-1:0] pending;                    // Write in flight per register
    logic                    use_rs;
    logic                    use_rt;
    logic                    stall;
    logic [NBITS-1:0]        ext_imm;
    opr_t                    opr_next;

    assign o_rs_sel = i_dec.rs;
    assign o_rt_sel = i_dec.rt;

    assign use_rs = !i_dec.sa_as_a;
    assign use_rt = !i_dec.imm_as_b;
    // One pending bit per register, so a second writer waits for the first
    assign stall  = i_dec_valid && ((use_rs && pending[i_dec.rs]) ||
                                    (use_rt && pending[i_dec.rt]) ||
                                    (i_dec.wr_en && pending[i_dec.dst]));
    assign o_take = i_dec_valid && !stall && !i_hold;

    assign ext_imm = (i_dec.ext == EXT_SIGN) ? {{16{i_dec.imm[15]}}, i_dec.imm} :
                                               {16'h0000, i_dec.imm};

    always_comb begin
        opr_next.pc      = i_dec.pc;
        opr_next.opnd_a  = i_dec.sa_as_a ? {{(NBITS-5){1'b0}}, i_dec.sa} : i_rs_data;
        opr_next.opnd_b  = i_dec.imm_as_b ? ext_imm : i_rt_data;
        opr_next.alu_op  = i_dec.alu_op;
        opr_next.dst     = i_dec.dst;
        opr_next.wr_en   = i_dec.wr_en;
        opr_next.illegal = i_dec.illegal;
    end

    // A set in the same cycle overrides a clear
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending <= '0;
        end else begin
            if (i_clr_en) pending[i_clr_sel] <= 1'b0;
            if (o_take && i_dec.wr_en && (i_dec.dst != '0)) begin
                pending[i_dec.dst] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_opr_valid <= 1'b0;
        end else if (!i_hold) begin
            o_opr_valid <= i_dec_valid && !stall;        // Bubble on a hazard
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) o_opr <= opr_next;
    end

endmodule

// File: design/execute_stage.sv
module execute_stage (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_opr_valid,
    input  cpu_pipe_pkg::opr_t i_opr,
    input  logic               i_hold,
    output logic               o_exe_valid,
    output cpu_pipe_pkg::exe_t o_exe
);
    import cpu_pipe_pkg::*;

    logic [NBITS-1:0] alu_res;
    exe_t             exe_next;

    always_comb begin
        case (i_opr.alu_op)
            ALU_ADD: alu_res = i_opr.opnd_a + i_opr.opnd_b;
            ALU_SUB: alu_res = i_opr.opnd_a - i_opr.opnd_b;
            ALU_AND: alu_res = i_opr.opnd_a & i_opr.opnd_b;
            ALU_OR:  alu_res = i_opr.opnd_a | i_opr.opnd_b;
            ALU_XOR: alu_res = i_opr.opnd_a ^ i_opr.opnd_b;
            ALU_SLT: alu_res = {{(NBITS-1){1'b0}},
                                $signed(i_opr.opnd_a) < $signed(i_opr.opnd_b)};
            ALU_SLL: alu_res = i_opr.opnd_b << i_opr.opnd_a[4:0];  // A holds shamt
            ALU_LUI: alu_res = i_opr.opnd_b << 16;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        exe_next.pc      = i_opr.pc;
        exe_next.result  = i_opr.illegal ? '0 : alu_res;
        exe_next.dst     = i_opr.dst;
        exe_next.wr_en   = i_opr.wr_en;
        exe_next.illegal = i_opr.illegal;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_exe_valid <= 1'b0;
        end else if (!i_hold) begin
            o_exe_valid <= i_opr_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_hold && i_opr_valid) o_exe <= exe_next;
    end

endmodule

// File: design/writeback_stage.sv
module writeback_stage (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_exe_valid,
    input  cpu_pipe_pkg::exe_t                 i_exe,
    input  logic                               i_wb_credit,
    output logic                               o_hold,
    output logic                               o_wr_en,
    output logic [cpu_pipe_pkg::REG_SEL_W-1:0] o_wr_sel,
    output logic [cpu_pipe_pkg::NBITS-1:0]     o_wr_data,
    output logic                               o_wb_valid,
    output cpu_pipe_pkg::wb_rec_t              o_wb_rec
);
    import cpu_pipe_pkg::*;

    logic [OUT_CRED_W-1:0] credits;
    logic                  out_full;
    logic                  send;
    logic                  accept;

    assign send   = out_full && (credits != '0);
    assign o_hold = out_full && (credits == '0);         // Record stuck without credit
    assign accept = i_exe_valid && !o_hold;

    // Register write and scoreboard release on acceptance
    assign o_wr_en    = accept && i_exe.wr_en;
    assign o_wr_sel   = i_exe.dst;
    assign o_wr_data  = i_exe.result;
    assign o_wb_valid = send;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits  <= OUT_CRED_W'(OUT_CREDITS);
            out_full <= 1'b0;
        end else begin
            credits <= credits + OUT_CRED_W'(i_wb_credit) - OUT_CRED_W'(send);
            if (accept) begin
                out_full <= 1'b1;
            end else if (send) begin
                out_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_wb_rec.pc      <= i_exe.pc;
            o_wb_rec.dst     <= i_exe.dst;
            o_wb_rec.result  <= i_exe.result;
            o_wb_rec.illegal <= i_exe.illegal;
        end
    end

endmodule

// File: design/cpu_pipe_top.sv
module cpu_pipe_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_instr_valid,
    input  logic [cpu_pipe_pkg::NBITS-1:0] i_instr,
    input  logic [cpu_pipe_pkg::NBITS-1:0] i_pc,
    input  logic                           i_wb_credit,
    output logic                           o_instr_credit,
    output logic                           o_wb_valid,
    output cpu_pipe_pkg::wb_rec_t          o_wb_rec
);
    import cpu_pipe_pkg::*;

    logic                 dec_valid;
    dec_t                 dec;
    logic                 opr_take;
    logic [REG_SEL_W-1:0] rs_sel;
    logic [REG_SEL_W-1:0] rt_sel;
    logic [NBITS-1:0]     rs_data;
    logic [NBITS-1:0]     rt_data;
    logic                 opr_valid;
    opr_t                 opr;
    logic                 exe_valid;
    exe_t                 exe;
    logic                 wb_hold;
    logic                 wr_en;
    logic [REG_SEL_W-1:0] wr_sel;
    logic [NBITS-1:0]     wr_data;

    decode_stage u_decode (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_instr_valid(i_instr_valid), .i_instr(i_instr), .i_pc(i_pc),
        .i_hold(!opr_take),                              // Held until operand takes it
        .o_instr_credit(o_instr_credit), .o_dec_valid(dec_valid), .o_dec(dec)
    );

    reg_file u_reg_file (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rs_sel(rs_sel), .i_rt_sel(rt_sel),
        .i_wr_en(wr_en), .i_rd_sel(wr_sel), .i_wr_data(wr_data),
        .o_rs_data(rs_data), .o_rt_data(rt_data)
    );

    operand_stage u_operand (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_dec_valid(dec_valid), .i_dec(dec), .i_hold(wb_hold),
        .i_rs_data(rs_data), .i_rt_data(rt_data),
        .i_clr_en(wr_en), .i_clr_sel(wr_sel),            // Writeback releases scoreboard
        .o_take(opr_take), .o_rs_sel(rs_sel), .o_rt_sel(rt_sel),
        .o_opr_valid(opr_valid), .o_opr(opr)
    );

    execute_stage u_execute (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_opr_valid(opr_valid), .i_opr(opr), .i_hold(wb_hold),
        .o_exe_valid(exe_valid), .o_exe(exe)
    );

    writeback_stage u_writeback (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_exe_valid(exe_valid), .i_exe(exe), .i_wb_credit(i_wb_credit),
        .o_hold(wb_hold), .o_wr_en(wr_en), .o_wr_sel(wr_sel), .o_wr_data(wr_data),
        .o_wb_valid(o_wb_valid), .o_wb_rec(o_wb_rec)
    );

endmodule

// File: verification/tb_cpu_pipe.sv
module tb_cpu_pipe;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pipe_pkg::*;

    localparam int N_INSTR = 20;
    localparam int N_COLS  = 5;                          // pc, instr, dst, result, illegal
    localparam int TIMEOUT = 40 * N_INSTR + 200;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             instr_valid;
    logic [NBITS-1:0] instr;
    logic [NBITS-1:0] pc;
    logic             wb_credit;
    logic             instr_credit;
    logic             wb_valid;
    wb_rec_t          wb_rec;

    logic [31:0] vec [N_INSTR*N_COLS];
    logic [31:0] lcg_state = 32'h09ca_3a01;
    int          errors      = 0;
    int          cycles      = 0;
    int          in_credits  = IN_DEPTH;                 // Source side credit count
    int          send_idx    = 0;
    int          rec_idx     = 0;
    int          outstanding = 0;                        // Records not yet credited back

    cpu_pipe_top u_dut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_instr_valid(instr_valid), .i_instr(instr), .i_pc(pc),
        .i_wb_credit(wb_credit),
        .o_instr_credit(instr_credit), .o_wb_valid(wb_valid), .o_wb_rec(wb_rec)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
            wb_credit   <= 1'b0;
        end else begin
            cycles++;
            if (instr_credit) in_credits++;
            if (in_credits > IN_DEPTH) begin
                errors++;
                $display("ERROR at %0t: source holds %0d input credits, more than the FIFO depth",
                         $time, in_credits);
            end
            if (in_credits > 0 && send_idx < N_INSTR) begin
                instr_valid <= 1'b1;
                pc          <= vec[send_idx*N_COLS];
                instr       <= vec[send_idx*N_COLS+1];
                in_credits--;                            // Spent on this send
                send_idx++;
            end else begin
                instr_valid <= 1'b0;
            end

            if (wb_valid) begin
                outstanding++;
                if (outstanding > OUT_CREDITS) begin
                    errors++;
                    $display("ERROR at %0t: %0d records outstanding, sink only has %0d credits",
                             $time, outstanding, OUT_CREDITS);
                end
                if (rec_idx >= N_INSTR) begin
                    errors++;
                    $display("ERROR at %0t: record received after the last instruction", $time);
                end else begin
                    check_value("o_wb_rec.pc", vec[rec_idx*N_COLS], wb_rec.pc);
                    check_value("o_wb_rec.dst", vec[rec_idx*N_COLS+2], 32'(wb_rec.dst));
                    check_value("o_wb_rec.result", vec[rec_idx*N_COLS+3], wb_rec.result);
                    check_value("o_wb_rec.illegal", vec[rec_idx*N_COLS+4],
                                32'(wb_rec.illegal));
                end
                rec_idx++;
            end

            // Random delay before each credit goes back
            if (outstanding > 0) begin
                lcg_state = lcg_next(lcg_state);
                if (lcg_state[31:30] != 2'b00) begin
                    wb_credit <= 1'b1;
                    outstanding--;
                end else begin
                    wb_credit <= 1'b0;
                end
            end else begin
                wb_credit <= 1'b0;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        wb_credit   = 1'b0;
        $readmemh("verification/cpu_pipe_input.txt", vec);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("o_instr_credit", 32'd0, 32'(instr_credit));
        check_value("o_wb_valid", 32'd0, 32'(wb_valid));
        while (rec_idx < N_INSTR && cycles < TIMEOUT) @(negedge clk);
        if (rec_idx < N_INSTR) begin
            errors++;
            $display("ERROR: pipeline stalled, %0d of %0d records after %0d cycles",
                     rec_idx, N_INSTR, cycles);
        end
        repeat (8) @(negedge clk);                       // Catch stray records and credits
        check_value("input credits", 32'(IN_DEPTH), 32'(in_credits));
        $display("Errors: %0d, records: %0d of %0d", errors, rec_idx, N_INSTR);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verification/cpu_pipe_input.txt
// Columns, all hex: pc, instruction word, expected dst, expected result, expected illegal
// One instruction per line, in program order
00000000 24010005 00000001 00000005 00000000
00000004 2402fffd 00000002 fffffffd 00000000
00000008 00221821 00000003 00000002 00000000
0000000c 00612023 00000004 fffffffd 00000000
00000010 0081282a 00000005 00000001 00000000
00000014 00013100 00000006 00000050 00000000
00000018 00c23824 00000007 00000050 00000000
0000001c 00c14025 00000008 00000055 00000000
00000020 01024826 00000009 ffffffa8 00000000
00000024 284afffe 0000000a 00000001 00000000
00000028 304bfff0 0000000b 0000fff0 00000000
0000002c 340c8001 0000000c 00008001 00000000
00000030 398dffff 0000000d 00007ffe 00000000
00000034 3c0e8765 0000000e 87650000 00000000
00000038 00210021 00000000 0000000a 00000000
0000003c 00017821 0000000f 00000005 00000000
00000040 8c210000 00000000 00000000 00000001
00000044 00220818 00000000 00000000 00000001
00000048 24300000 00000010 00000005 00000000
0000004c 01cd8823 00000011 87648002 00000000

// File: cpu_pipe.f
design/cpu_pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/operand_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu_pipe_top.sv
verification/tb_cpu_pipe.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_cpu_pipe -f cpu_pipe.f \
    -Mdir obj_dir -o Vtb_cpu_pipe \
    && ./obj_dir/Vtb_cpu_pipe | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
